// File: src/ccd_pkg.sv
/*
 * ccd timing package
 * field widths, the packed timing configuration, the frame states
 * and the counter bundle passed from the frame fsm to the pulse decoder
 */

package ccd_pkg;

	//------------------------------------------------------------
	// widths
	//------------------------------------------------------------
	localparam int LINE_WD  = 12;	// pixel-in-line counter and line fields
	localparam int FRAME_WD = 12;	// line counter and frame fields
	localparam int XV_WD    = 2;	// vertical transfer phase

	// frame states
	typedef enum logic [1:0] {
		st_idle      = 2'd0,	// no acquisition
		st_wait_trig = 2'd1,	// trigger mode, between frames
		st_expose    = 2'd2,	// lines below exp_lines
		st_readout   = 2'd3		// rest of the frame
	} frame_state_e;

	//------------------------------------------------------------
	// timing registers, 14 fields, 168 bits
	//------------------------------------------------------------
	typedef struct packed {
		logic [LINE_WD-1:0]  line_period;	// pixels per line
		logic [LINE_WD-1:0]  href_start;
		logic [LINE_WD-1:0]  href_end;
		logic [LINE_WD-1:0]  hd_rising;		// afe line sync window
		logic [LINE_WD-1:0]  hd_falling;
		logic [LINE_WD-1:0]  sub_rising;	// shutter pulse, line 0 only
		logic [LINE_WD-1:0]  sub_falling;
		logic [LINE_WD-1:0]  xsg_width;		// charge transfer width in pixels
		logic [FRAME_WD-1:0] frame_period;	// lines per frame
		logic [FRAME_WD-1:0] vd_rising;		// afe frame sync window
		logic [FRAME_WD-1:0] vd_falling;
		logic [FRAME_WD-1:0] vref_start;	// valid lines, readout only
		logic [FRAME_WD-1:0] vref_end;
		logic [FRAME_WD-1:0] exp_lines;		// expose length, at least 1
	} ccd_cfg_t;

	// frame position, fsm to pulse decoder
	typedef struct packed {
		logic [LINE_WD-1:0]  pix_cnt;
		logic [FRAME_WD-1:0] line_cnt;
		frame_state_e        state;
	} ccd_cnt_t;

endpackage

// File: src/ccd_reg.sv
/*
 * ccd register input side
 * synchronizes acquisition start and stream enable into one run level
 * and keeps the shadow timing configuration and trigger mode, which
 * are only taken at frame boundaries
 */

`timescale 1ns/1ps

module ccd_reg import ccd_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  ccd_cfg_t i_cfg,					// live register values
	input  logic     i_acquisition_start,	// async level
	input  logic     i_stream_enable,		// async level
	input  logic     i_triggermode,			// 1 = trigger, 0 = free run
	input  logic     i_reg_active,			// cycle before line 0 pixel 0
	output ccd_cfg_t o_cfg,					// shadow copy
	output logic     o_run,
	output logic     o_triggermode			// accepted trigger mode
);

	logic [1:0] acq_sync;	// two-flop sync, acquisition start
	logic [1:0] se_sync;	// two-flop sync, stream enable

	//------------------------------------------------------------
	// control level synchronizer
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			acq_sync <= 2'b00;
			se_sync  <= 2'b00;
		end else begin
			acq_sync <= {acq_sync[0], i_acquisition_start};
			se_sync  <= {se_sync[0], i_stream_enable};
		end
	end

	// both levels must agree before frames run
	always_ff @(posedge clk) begin
		if (reset) begin
			o_run <= 1'b0;
		end else begin
			o_run <= acq_sync[1] & se_sync[1];	// edge N input -> edge N+2
		end
	end

	//------------------------------------------------------------
	// shadow configuration
	//------------------------------------------------------------
	// loaded during reset so the first frame has sane values,
	// then only on the frame start pulse
	always_ff @(posedge clk) begin
		if (reset || i_reg_active) begin
			o_cfg <= i_cfg;
		end
	end

	// trigger mode follows the same frame boundary
	always_ff @(posedge clk) begin
		if (reset || i_reg_active) begin
			o_triggermode <= i_triggermode;
		end
	end

endmodule

// File: src/ccd_frame_fsm.sv
/*
 * ccd frame state machine
 * runs the pixel and line counters, steps idle, wait_trig, expose and
 * readout at line and frame ends, and issues the shadow update pulse
 * and the end-of-exposure pulse
 */

`timescale 1ns/1ps

module ccd_frame_fsm import ccd_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  ccd_cfg_t i_cfg,				// shadow configuration
	input  logic     i_run,				// synchronized run level
	input  logic     i_triggermode,		// accepted trigger mode
	input  logic     i_trigger,			// already masked, one per window
	output ccd_cnt_t o_cnt,
	output logic     o_reg_active,		// cycle before line 0 pixel 0
	output logic     o_exposure_end,	// last expose cycle
	output logic     o_trig_window		// high in wait_trig
);

	frame_state_e        state_q;
	logic [LINE_WD-1:0]  pix_q;
	logic [FRAME_WD-1:0] line_q;

	logic                in_frame;		// expose or readout
	logic                pix_last;		// last pixel of the line
	logic                line_last;		// last line of the frame
	logic                line_end;
	logic                frame_end;
	logic                exp_last_line;	// next line leaves expose
	logic                frame_start;

	//------------------------------------------------------------
	// position decode
	//------------------------------------------------------------
	always_comb begin
		in_frame      = (state_q == st_expose) || (state_q == st_readout);
		pix_last      = (pix_q == i_cfg.line_period - LINE_WD'(1));
		line_last     = (line_q == i_cfg.frame_period - FRAME_WD'(1));
		line_end      = in_frame && pix_last;
		frame_end     = line_end && line_last;
		exp_last_line = (line_q + FRAME_WD'(1) == i_cfg.exp_lines);
	end

	// every way into a new frame
	always_comb begin
		frame_start = 1'b0;
		case (state_q)
			st_idle:      frame_start = i_run;	// first frame needs no trigger
			st_wait_trig: frame_start = i_run && i_trigger;
			default:      frame_start = frame_end && i_run && !i_triggermode;
		endcase
	end

	assign o_reg_active   = frame_start;	// shadow loads on the same edge
	assign o_exposure_end = (state_q == st_expose) && line_end &&
	                        (exp_last_line || line_last);	// expose may fill the frame
	assign o_trig_window  = (state_q == st_wait_trig);

	//------------------------------------------------------------
	// state and counters
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= st_idle;
			pix_q   <= '0;
			line_q  <= '0;
		end else if (frame_start) begin
			state_q <= st_expose;	// line 0 is always exposure
			pix_q   <= '0;
			line_q  <= '0;
		end else begin
			case (state_q)
				st_idle: begin
					pix_q  <= '0;
					line_q <= '0;
				end
				st_wait_trig: begin
					if (!i_run) begin
						state_q <= st_idle;		// acquisition stopped while waiting
					end
				end
				default: begin
					if (frame_end) begin
						pix_q   <= '0;
						line_q  <= '0;
						state_q <= i_run ? st_wait_trig : st_idle;	// free run handled above
					end else if (line_end) begin
						pix_q  <= '0;
						line_q <= line_q + FRAME_WD'(1);
						if (state_q == st_expose && exp_last_line) begin
							state_q <= st_readout;
						end
					end else begin
						pix_q <= pix_q + LINE_WD'(1);
					end
				end
			endcase
		end
	end

	// counter bundle to the decoder
	always_comb begin
		o_cnt.pix_cnt  = pix_q;
		o_cnt.line_cnt = line_q;
		o_cnt.state    = state_q;
	end

endmodule

// File: src/ccd_pulse_gen.sv
/*
 * ccd pulse generator
 * decodes the frame position into the sensor pulses (sub, xsg, xv)
 * and the afe and pixel path levels, one register stage late
 */

`timescale 1ns/1ps

module ccd_pulse_gen import ccd_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  ccd_cnt_t         i_cnt,		// position and state from the fsm
	input  ccd_cfg_t         i_cfg,		// shadow configuration
	output logic             o_hd,			// afe line sync
	output logic             o_vd,			// afe frame sync
	output logic             o_href,		// line valid
	output logic             o_vref,		// frame valid
	output logic             o_sub,			// electronic shutter
	output logic             o_xsg,			// charge transfer
	output logic             o_integration,
	output logic [XV_WD-1:0] ov_xv			// vertical transfer phase, gray
);

	logic active;		// expose or readout
	logic readout;
	logic hd_c;
	logic vd_c;
	logic vref_c;
	logic href_c;
	logic sub_c;
	logic xsg_c;

	// 00 -> 01 -> 11 -> 10 -> 00
	function automatic logic [XV_WD-1:0] gray_step(input logic [XV_WD-1:0] g);
		logic [XV_WD-1:0] b;
		b = {g[1], g[1] ^ g[0]};	// gray to binary
		b = b + XV_WD'(1);
		return b ^ (b >> 1);
	endfunction

	//------------------------------------------------------------
	// window decode
	//------------------------------------------------------------
	always_comb begin
		active  = (i_cnt.state == st_expose) || (i_cnt.state == st_readout);
		readout = (i_cnt.state == st_readout);
		hd_c    = active && (i_cnt.pix_cnt >= i_cfg.hd_rising) &&
		          (i_cnt.pix_cnt < i_cfg.hd_falling);
		vd_c    = active && (i_cnt.line_cnt >= i_cfg.vd_rising) &&
		          (i_cnt.line_cnt < i_cfg.vd_falling);
		vref_c  = readout && (i_cnt.line_cnt >= i_cfg.vref_start) &&
		          (i_cnt.line_cnt < i_cfg.vref_end);
		href_c  = vref_c && (i_cnt.pix_cnt >= i_cfg.href_start) &&
		          (i_cnt.pix_cnt < i_cfg.href_end);	// only inside valid lines
		sub_c   = active && (i_cnt.line_cnt == '0) &&
		          (i_cnt.pix_cnt >= i_cfg.sub_rising) &&
		          (i_cnt.pix_cnt < i_cfg.sub_falling);
		xsg_c   = active && (i_cnt.line_cnt == i_cfg.exp_lines) &&
		          (i_cnt.pix_cnt < i_cfg.xsg_width);	// first readout line
	end

	//------------------------------------------------------------
	// output registers
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			o_hd          <= 1'b0;
			o_vd          <= 1'b0;
			o_href        <= 1'b0;
			o_vref        <= 1'b0;
			o_sub         <= 1'b0;
			o_xsg         <= 1'b0;
			o_integration <= 1'b0;
		end else begin
			o_hd          <= hd_c;
			o_vd          <= vd_c;
			o_href        <= href_c;
			o_vref        <= vref_c;
			o_sub         <= sub_c;
			o_xsg         <= xsg_c;
			o_integration <= (i_cnt.state == st_expose);
		end
	end

	// vertical transfer, one phase step per readout line
	always_ff @(posedge clk) begin
		if (reset || !readout) begin
			ov_xv <= '0;
		end else if (i_cnt.pix_cnt == '0) begin
			ov_xv <= gray_step(ov_xv);
		end
	end

endmodule

// File: src/mv_ccd.sv
/*
 * ccd timing generator top level
 * ties the register side, frame fsm and pulse decoder together, and
 * adds the stop flag, the one-per-frame trigger mask and the stretched
 * end-of-exposure pulse
 */

`timescale 1ns/1ps

module mv_ccd import ccd_pkg::*; #(
	parameter int STOP_DELAY = 64	// cycles from run low to stop flag
) (
	input  logic             clk,
	input  logic             reset,
	input  ccd_cfg_t         i_cfg,
	input  logic             i_acquisition_start,
	input  logic             i_stream_enable,
	input  logic             i_trigger,			// one-cycle pulse
	input  logic             i_triggermode,
	output logic             o_hd,
	output logic             o_vd,
	output logic             o_href,
	output logic             o_vref,
	output logic             o_sub,
	output logic             o_xsg,
	output logic [XV_WD-1:0] ov_xv,
	output logic             o_integration,
	output logic             o_exposure_end,	// four cycles wide
	output logic             o_trigger_mask,
	output logic             o_ccd_stop_flag
);

	localparam int STOP_WD = (STOP_DELAY > 1) ? $clog2(STOP_DELAY) : 1;

	ccd_cfg_t           cfg_shadow;
	ccd_cnt_t           cnt;
	logic               run;
	logic               trigmode_acc;
	logic               reg_active;
	logic               exp_end_pulse;	// single cycle from the fsm
	logic               trig_window;
	logic               trig_first;		// first trigger in the window
	logic [2:0]         exp_end_dly;
	logic [STOP_WD-1:0] stop_cnt;

	//------------------------------------------------------------
	// blocks
	//------------------------------------------------------------
	ccd_reg u_reg (
		.clk                 (clk),
		.reset               (reset),
		.i_cfg               (i_cfg),
		.i_acquisition_start (i_acquisition_start),
		.i_stream_enable     (i_stream_enable),
		.i_triggermode       (i_triggermode),
		.i_reg_active        (reg_active),
		.o_cfg               (cfg_shadow),
		.o_run               (run),
		.o_triggermode       (trigmode_acc)
	);

	ccd_frame_fsm u_fsm (
		.clk            (clk),
		.reset          (reset),
		.i_cfg          (cfg_shadow),
		.i_run          (run),
		.i_triggermode  (trigmode_acc),
		.i_trigger      (trig_first),
		.o_cnt          (cnt),
		.o_reg_active   (reg_active),
		.o_exposure_end (exp_end_pulse),
		.o_trig_window  (trig_window)
	);

	ccd_pulse_gen u_pulse (
		.clk           (clk),
		.reset         (reset),
		.i_cnt         (cnt),
		.i_cfg         (cfg_shadow),
		.o_hd          (o_hd),
		.o_vd          (o_vd),
		.o_href        (o_href),
		.o_vref        (o_vref),
		.o_sub         (o_sub),
		.o_xsg         (o_xsg),
		.o_integration (o_integration),
		.ov_xv         (ov_xv)
	);

	//------------------------------------------------------------
	// stop flag, STOP_DELAY cycles after run drops
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			o_ccd_stop_flag <= 1'b1;
			stop_cnt        <= '0;
		end else if (run) begin
			o_ccd_stop_flag <= 1'b0;	// falls as soon as run is seen
			stop_cnt        <= '0;
		end else if (!o_ccd_stop_flag) begin
			if (stop_cnt == STOP_WD'(STOP_DELAY - 1)) begin
				o_ccd_stop_flag <= 1'b1;
			end else begin
				stop_cnt <= stop_cnt + STOP_WD'(1);
			end
		end
	end

	// trigger mask, only the first trigger of a window reaches the fsm
	assign trig_first = i_trigger && trig_window && !o_trigger_mask;

	always_ff @(posedge clk) begin
		if (reset || !trig_window) begin
			o_trigger_mask <= 1'b0;		// cleared once the window closes
		end else if (trig_first) begin
			o_trigger_mask <= 1'b1;
		end
	end

	// exposure end stretch
	always_ff @(posedge clk) begin
		if (reset) begin
			exp_end_dly    <= '0;
			o_exposure_end <= 1'b0;
		end else begin
			exp_end_dly    <= {exp_end_dly[1:0], exp_end_pulse};
			o_exposure_end <= exp_end_pulse | (|exp_end_dly);	// 4-stage or
		end
	end

endmodule

// File: tests/mv_ccd_assertions.sv
/*
 * ccd timing output checks, bound into mv_ccd
 * valid nesting, xsg against href, exposure end width, trigger mask
 */

`timescale 1ns/1ps

module mv_ccd_assertions (
	input logic clk,
	input logic reset,
	input logic i_href,
	input logic i_vref,
	input logic i_xsg,
	input logic i_exposure_end,
	input logic i_trigger_mask,
	input logic i_trig_window	// fsm wait_trig level
);

	// line valid only inside frame valid
	a_href_in_vref: assert property (@(posedge clk) disable iff (reset) i_href |-> i_vref)
		else $error("o_href high while o_vref is low");

	// charge transfer never lands on valid pixels
	a_xsg_href: assert property (@(posedge clk) disable iff (reset) !(i_xsg && i_href))
		else $error("o_xsg overlaps o_href");

	// stretched pulse, rise plus three more cycles, then low
	a_exp_end_width: assert property (@(posedge clk) disable iff (reset)
		$rose(i_exposure_end) |=> i_exposure_end ##1 i_exposure_end ##1 i_exposure_end
		##1 !i_exposure_end)
		else $error("o_exposure_end not four cycles wide");

	// accepted trigger starts the frame, so the window is shut when the mask shows
	a_mask_hold: assert property (@(posedge clk) disable iff (reset)
		$rose(i_trigger_mask) |-> !i_trig_window)
		else $error("trigger window still open after the mask went high");

endmodule

bind mv_ccd mv_ccd_assertions u_assertions (
	.clk            (clk),
	.reset          (reset),
	.i_href         (o_href),
	.i_vref         (o_vref),
	.i_xsg          (o_xsg),
	.i_exposure_end (o_exposure_end),
	.i_trigger_mask (o_trigger_mask),
	.i_trig_window  (trig_window)
);

// File: tests/tb_mv_ccd.sv
/*
 * testbench for the ccd timing generator
 * random small configurations from a fixed-seed lcg, a cycle model of
 * the frame and decode rules, and a compare of every output each cycle
 */

`timescale 1ns/1ps

module tb_mv_ccd import ccd_pkg::*; ();

	localparam int STOP_DELAY = 24;		// short stop delay keeps the run quick
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_WAIT = 2'd1;
	localparam logic [1:0] S_EXP  = 2'd2;
	localparam logic [1:0] S_READ = 2'd3;

	// expected registered levels
	typedef struct packed {
		logic hd;
		logic vd;
		logic href;
		logic vref;
		logic sub;
		logic xsg;
		logic integ;
	} level_t;

	logic             clk;
	logic             reset;
	ccd_cfg_t         i_cfg;
	logic             i_acquisition_start;
	logic             i_stream_enable;
	logic             i_trigger;
	logic             i_triggermode;
	logic             o_hd, o_vd, o_href, o_vref, o_sub, o_xsg;
	logic             o_integration, o_exposure_end, o_trigger_mask, o_ccd_stop_flag;
	logic [XV_WD-1:0] ov_xv;

	// model state
	logic [1:0]          a_sync, s_sync;	// two-flop sync copies
	logic                m_run, m_tmode, m_mask, m_stop, m_exp_end;
	logic [2:0]          m_dly;
	int                  m_stop_cnt;
	logic [1:0]          m_state;
	logic [LINE_WD-1:0]  m_pix;
	logic [FRAME_WD-1:0] m_line;
	ccd_cfg_t            m_cfg;				// config latched at frame start
	level_t              m_lv;
	logic [XV_WD-1:0]    m_xv;

	logic [31:0] seed;
	int          value_errors, other_errors, checks, mask_rises;
	logic        mask_prev;
	string       phase;

	mv_ccd #(.STOP_DELAY(STOP_DELAY)) u_dut (
		.clk(clk), .reset(reset), .i_cfg(i_cfg),
		.i_acquisition_start(i_acquisition_start), .i_stream_enable(i_stream_enable),
		.i_trigger(i_trigger), .i_triggermode(i_triggermode),
		.o_hd(o_hd), .o_vd(o_vd), .o_href(o_href), .o_vref(o_vref), .o_sub(o_sub),
		.o_xsg(o_xsg), .ov_xv(ov_xv), .o_integration(o_integration),
		.o_exposure_end(o_exposure_end), .o_trigger_mask(o_trigger_mask),
		.o_ccd_stop_flag(o_ccd_stop_flag)
	);

	always #20 clk = ~clk;	// 40 ns period

	//------------------------------------------------------------
	// random numbers and configurations
	//------------------------------------------------------------
	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = lcg_next();
		return lo + int'({8'd0, r[31:8]} % (hi - lo + 1));	// upper bits, better spread
	endfunction

	// windows ordered inside the periods, href kept clear of xsg
	function automatic ccd_cfg_t random_cfg();
		ccd_cfg_t c;
		c.line_period  = LINE_WD'(rand_range(20, 40));
		c.frame_period = FRAME_WD'(rand_range(8, 14));
		c.xsg_width    = LINE_WD'(rand_range(1, 4));
		c.href_start   = c.xsg_width + LINE_WD'(rand_range(1, 4));
		c.href_end     = c.href_start +
		                 LINE_WD'(rand_range(1, int'(c.line_period - c.href_start)));
		c.hd_rising    = LINE_WD'(rand_range(0, 3));
		c.hd_falling   = c.hd_rising + LINE_WD'(rand_range(1, 6));
		c.sub_rising   = LINE_WD'(rand_range(0, 4));
		c.sub_falling  = c.sub_rising + LINE_WD'(rand_range(1, 8));
		c.exp_lines    = FRAME_WD'(rand_range(1, int'(c.frame_period) - 3));
		c.vd_rising    = FRAME_WD'(rand_range(0, 1));
		c.vd_falling   = c.vd_rising + FRAME_WD'(rand_range(1, 2));
		c.vref_start   = c.exp_lines + FRAME_WD'(rand_range(0, 1));
		c.vref_end     = c.vref_start +
		                 FRAME_WD'(rand_range(1, int'(c.frame_period - c.vref_start)));
		return c;
	endfunction

	//------------------------------------------------------------
	// reference model
	//------------------------------------------------------------
	function automatic level_t expect_levels(input logic [1:0] st,
			input logic [LINE_WD-1:0] pix, input logic [FRAME_WD-1:0] line,
			input ccd_cfg_t c);
		level_t r;
		logic   act;
		act     = (st == S_EXP) || (st == S_READ);
		r.hd    = act && pix >= c.hd_rising && pix < c.hd_falling;
		r.vd    = act && line >= c.vd_rising && line < c.vd_falling;
		r.vref  = (st == S_READ) && line >= c.vref_start && line < c.vref_end;
		r.href  = r.vref && pix >= c.href_start && pix < c.href_end;
		r.sub   = act && line == '0 && pix >= c.sub_rising && pix < c.sub_falling;
		r.xsg   = act && line == c.exp_lines && pix < c.xsg_width;
		r.integ = (st == S_EXP);
		return r;
	endfunction

	// gray sequence 00 01 11 10
	function automatic logic [XV_WD-1:0] next_phase(input logic [XV_WD-1:0] p);
		case (p)
			2'b00:   return 2'b01;
			2'b01:   return 2'b11;
			2'b11:   return 2'b10;
			default: return 2'b00;
		endcase
	endfunction

	always @(posedge clk) begin : model_step
		logic run_old;
		logic trig_ok;
		logic line_end;
		logic frame_end;
		logic start;
		logic exp_pulse;
		if (reset) begin
			a_sync     = 2'b00;
			s_sync     = 2'b00;
			m_run      = 1'b0;
			m_state    = S_IDLE;
			m_pix      = '0;
			m_line     = '0;
			m_cfg      = i_cfg;		// shadow follows the bus in reset
			m_tmode    = i_triggermode;
			m_lv       = '0;
			m_xv       = '0;
			m_dly      = '0;
			m_exp_end  = 1'b0;
			m_mask     = 1'b0;
			m_stop     = 1'b1;
			m_stop_cnt = 0;
		end else begin
			run_old   = m_run;
			m_run     = a_sync[1] & s_sync[1];
			a_sync    = {a_sync[0], i_acquisition_start};
			s_sync    = {s_sync[0], i_stream_enable};
			trig_ok   = i_trigger && (m_state == S_WAIT) && !m_mask;
			line_end  = (m_state == S_EXP || m_state == S_READ) &&
			            m_pix == m_cfg.line_period - LINE_WD'(1);
			frame_end = line_end && m_line == m_cfg.frame_period - FRAME_WD'(1);
			exp_pulse = (m_state == S_EXP) && line_end &&
			            ((m_line + FRAME_WD'(1) == m_cfg.exp_lines) || frame_end);
			case (m_state)
				S_IDLE:  start = run_old;
				S_WAIT:  start = run_old && trig_ok;
				default: start = frame_end && run_old && !m_tmode;
			endcase
			// outputs lag the position by one edge
			m_lv = expect_levels(m_state, m_pix, m_line, m_cfg);
			if (m_state != S_READ) begin
				m_xv = '0;
			end else if (m_pix == '0) begin
				m_xv = next_phase(m_xv);
			end
			m_exp_end = exp_pulse | (|m_dly);
			m_dly     = {m_dly[1:0], exp_pulse};
			if (run_old) begin
				m_stop     = 1'b0;
				m_stop_cnt = 0;
			end else if (!m_stop) begin
				if (m_stop_cnt == STOP_DELAY - 1) m_stop = 1'b1;
				else m_stop_cnt++;
			end
			if (m_state != S_WAIT) m_mask = 1'b0;
			else if (trig_ok) m_mask = 1'b1;
			// frame position
			if (start) begin
				m_cfg   = i_cfg;
				m_tmode = i_triggermode;
				m_state = S_EXP;
				m_pix   = '0;
				m_line  = '0;
			end else if (m_state == S_WAIT) begin
				if (!run_old) m_state = S_IDLE;
			end else if (m_state != S_IDLE) begin
				if (frame_end) begin
					m_state = run_old ? S_WAIT : S_IDLE;
					m_pix   = '0;
					m_line  = '0;
				end else if (line_end) begin
					if (m_state == S_EXP && m_line + FRAME_WD'(1) == m_cfg.exp_lines) begin
						m_state = S_READ;
					end
					m_pix  = '0;
					m_line = m_line + FRAME_WD'(1);
				end else begin
					m_pix = m_pix + LINE_WD'(1);
				end
			end
		end
	end

	//------------------------------------------------------------
	// per-cycle compare, away from the clock edge
	//------------------------------------------------------------
	task automatic report_bit(input string sig, input logic exp, input logic act);
		value_errors++;
		$display("Error: %s %s expected %0b actual %0b at %0t", phase, sig, exp, act, $time);
	endtask

	task automatic report_xv(input logic [XV_WD-1:0] exp, input logic [XV_WD-1:0] act);
		value_errors++;
		$display("Error: %s ov_xv expected %0h actual %0h at %0t", phase, exp, act, $time);
	endtask

	always @(negedge clk) begin
		if (!reset) begin
			checks++;
			if (o_hd !== m_lv.hd) report_bit("o_hd", m_lv.hd, o_hd);
			if (o_vd !== m_lv.vd) report_bit("o_vd", m_lv.vd, o_vd);
			if (o_href !== m_lv.href) report_bit("o_href", m_lv.href, o_href);
			if (o_vref !== m_lv.vref) report_bit("o_vref", m_lv.vref, o_vref);
			if (o_sub !== m_lv.sub) report_bit("o_sub", m_lv.sub, o_sub);
			if (o_xsg !== m_lv.xsg) report_bit("o_xsg", m_lv.xsg, o_xsg);
			if (o_integration !== m_lv.integ) report_bit("o_integration", m_lv.integ, o_integration);
			if (ov_xv !== m_xv) report_xv(m_xv, ov_xv);
			if (o_exposure_end !== m_exp_end) report_bit("o_exposure_end", m_exp_end, o_exposure_end);
			if (o_trigger_mask !== m_mask) report_bit("o_trigger_mask", m_mask, o_trigger_mask);
			if (o_ccd_stop_flag !== m_stop) report_bit("o_ccd_stop_flag", m_stop, o_ccd_stop_flag);
			if (o_trigger_mask && !mask_prev) mask_rises++;
			mask_prev = o_trigger_mask;
		end
	end

	//------------------------------------------------------------
	// stimulus helpers, all waits bounded
	//------------------------------------------------------------
	task automatic step();
		@(posedge clk);
		#2;		// inputs change just after the edge
	endtask

	task automatic wait_frames(input int n);
		int   seen;
		int   t;
		logic prev;
		seen = 0;
		t    = 0;
		prev = o_integration;
		while (seen < n && t < 2000 * n) begin
			step();
			if (o_integration && !prev) seen++;	// one rise per frame
			prev = o_integration;
			t++;
		end
		if (seen < n) begin
			other_errors++;
			$display("%s: timed out waiting for %0d frame starts", phase, n);
		end
	endtask

	task automatic wait_window();
		int t;
		t = 0;
		while (!u_dut.trig_window && t < 2000) begin
			step();
			t++;
		end
		if (!u_dut.trig_window) begin
			other_errors++;
			$display("%s: trigger window never opened", phase);
		end
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		while (m_state != S_IDLE && t < 1200) begin
			step();
			t++;
		end
		if (m_state != S_IDLE) begin
			other_errors++;
			$display("%s: frames did not stop after acquisition ended", phase);
		end
	endtask

	task automatic wait_stop_flag(input logic level, input int limit, output int cycles);
		cycles = 0;
		while (o_ccd_stop_flag !== level && cycles < limit) begin
			step();
			cycles++;
		end
		if (o_ccd_stop_flag !== level) begin
			other_errors++;
			$display("%s: stop flag did not go to %0b within %0d cycles", phase, level, limit);
		end
	endtask

	// drop acquisition, stop flag must follow sync plus STOP_DELAY
	task automatic stop_and_check();
		int cycles;
		i_acquisition_start = 1'b0;
		wait_stop_flag(1'b1, STOP_DELAY + 10, cycles);
		if (cycles != STOP_DELAY + 3) begin
			other_errors++;
			$display("Error: %s stop delay expected %0d actual %0d", phase,
			         STOP_DELAY + 3, cycles);
		end
		wait_idle();
	endtask

	//------------------------------------------------------------
	// test sequence
	//------------------------------------------------------------
	initial begin
		int gap;
		int cycles;
		clk                 = 1'b0;
		reset               = 1'b1;
		seed                = 32'h6c475c23;
		i_acquisition_start = 1'b0;
		i_stream_enable     = 1'b0;
		i_trigger           = 1'b0;
		i_triggermode       = 1'b0;
		i_cfg               = random_cfg();
		value_errors        = 0;
		other_errors        = 0;
		checks              = 0;
		mask_rises          = 0;
		mask_prev           = 1'b0;
		phase               = "reset";
		repeat (8) @(posedge clk);
		#2;
		reset           = 1'b0;
		i_stream_enable = 1'b1;
		// nothing moves before acquisition start
		repeat (12) begin
			step();
			if (o_hd || o_vd || o_href || o_vref || o_sub || o_xsg || o_integration ||
			    o_exposure_end || o_trigger_mask || ov_xv != '0 || !o_ccd_stop_flag) begin
				other_errors++;
				$display("reset: outputs active before acquisition start");
			end
		end

		// free run, new config each pass, one change mid-frame
		for (int k = 0; k < 4; k++) begin
			phase               = "free_run";
			i_cfg               = random_cfg();
			i_acquisition_start = 1'b1;
			wait_stop_flag(1'b0, 8, cycles);	// restart clears the flag
			wait_frames(2);
			phase = "shadow";
			repeat (rand_range(5, 200)) step();
			i_cfg = random_cfg();
			wait_frames(2);
			phase = "stop";
			stop_and_check();
		end

		// trigger mode, switched on while frames run
		phase               = "trigger";
		i_cfg               = random_cfg();
		i_acquisition_start = 1'b1;
		wait_frames(1);
		i_triggermode = 1'b1;	// taken at the next frame start
		mask_rises    = 0;
		for (int f = 0; f < 4; f++) begin
			wait_window();
			gap = rand_range(0, 12);
			repeat (gap) begin
				step();
				if (o_hd || o_vd) begin
					other_errors++;
					$display("trigger: line or frame sync active while waiting for trigger");
				end
			end
			i_trigger = 1'b1;
			step();
			i_trigger = 1'b0;
			step();
			i_trigger = 1'b1;	// extra trigger, frame already running
			step();
			i_trigger = 1'b0;
			if (f == 2) i_cfg = random_cfg();
		end
		if (mask_rises < 4) begin
			other_errors++;
			$display("trigger: trigger mask went high %0d times for 4 triggers", mask_rises);
		end
		phase = "trigger_stop";
		wait_window();
		stop_and_check();

		// restart in trigger mode, first frame needs no trigger
		phase               = "restart";
		i_acquisition_start = 1'b1;
		wait_stop_flag(1'b0, 8, cycles);
		wait_frames(1);
		stop_and_check();

		step();
		step();
		$display("checks %0d, value errors %0d, other errors %0d",
		         checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: mv_ccd.f
src/ccd_pkg.sv
src/ccd_reg.sv
src/ccd_frame_fsm.sv
src/ccd_pulse_gen.sv
src/mv_ccd.sv
tests/mv_ccd_assertions.sv
tests/tb_mv_ccd.sv

// File: run_sim.sh
#!/bin/sh
# builds the mv_ccd testbench with verilator and runs it
# exit status is non-zero when the build, the run or the log check fails

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_mv_ccd

verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" -f mv_ccd.f -o "$TOP"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit 1
fi

# the testbench prints its verdict, the log decides
if grep -q "Verification failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
	echo "no verdict found in $LOG"
	exit 1
fi
exit 0
